/* logic/csr_defines.svh */
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// User counters and their time aliases
`define CSR_ADDR_CYCLE      12'hC00
`define CSR_ADDR_CYCLEH     12'hC80
`define CSR_ADDR_TIME       12'hC01
`define CSR_ADDR_TIMEH      12'hC81
`define CSR_ADDR_INSTRET    12'hC02
`define CSR_ADDR_INSTRETH   12'hC82

// Machine information and scratch
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MSCRATCH   12'h340

// 32-bit base ISA
`define CSR_MISA_MXL        2'b01

`define CSR_HART_INDEX_WIDTH 8

`endif

/* logic/csrPkg.sv */
package csrPkg;

	// Address field of a CSR instruction
	typedef logic [11:0] csrAddr_t;

	// One register word on the read and write ports
	typedef logic [31:0] csrData_t;

	// Full width of cycle and instret
	typedef logic [63:0] csrCounter_t;

endpackage

/* logic/csrCounter.sv */
`timescale 1ns/10ps

`include "csr_defines.svh"

module csrCounter #(
	parameter csrPkg::csrAddr_t addrLow = `CSR_ADDR_CYCLE,
	parameter csrPkg::csrAddr_t addrHigh = `CSR_ADDR_CYCLEH,
	parameter csrPkg::csrAddr_t aliasLow = `CSR_ADDR_TIME,
	parameter csrPkg::csrAddr_t aliasHigh = `CSR_ADDR_TIMEH
) (
	input logic clk,
	input logic arstN,
	input logic countEnable,
	input logic csrReadEnable,
	input logic csrWriteEnable,
	input csrPkg::csrAddr_t csrAddress,
	output logic hit,
	output logic writeDenied,
	output csrPkg::csrData_t readData
);

	csrPkg::csrCounter_t count;
	logic lowSel;
	logic highSel;
	logic anySel;
	logic anyStrobe;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
		end else if (countEnable) begin
			count <= count + 64'd1;
		end
	end

	// Alias pair may equal the primary pair
	assign lowSel = (csrAddress == addrLow) || (csrAddress == aliasLow);
	assign highSel = (csrAddress == addrHigh) || (csrAddress == aliasHigh);
	assign anySel = lowSel || highSel;
	assign anyStrobe = csrReadEnable || csrWriteEnable;

	// Sampled before this edge's increment
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hit <= 1'b0;
			writeDenied <= 1'b0;
			readData <= '0;
		end else begin
			hit <= anyStrobe && anySel;
			writeDenied <= csrWriteEnable && anySel;
			if (csrReadEnable && lowSel) begin
				readData <= count[31:0];
			end else if (csrReadEnable && highSel) begin
				readData <= count[63:32];
			end else begin
				readData <= '0;
			end
		end
	end

	// Responses only follow a strobe
	assert property (@(posedge clk) disable iff (!arstN)
		!anyStrobe |=> !hit && (readData == '0));

endmodule

/* logic/csrMachineBank.sv */
`timescale 1ns/10ps

`include "csr_defines.svh"

module csrMachineBank (
	input logic clk,
	input logic arstN,
	input logic csrReadEnable,
	input logic csrWriteEnable,
	input csrPkg::csrAddr_t csrAddress,
	input csrPkg::csrData_t csrWriteData,
	input logic [10:0] manufacturerId,
	input logic [15:0] partId,
	input logic [3:0] versionId,
	input logic [`CSR_HART_INDEX_WIDTH-1:0] coreIndex,
	input logic [25:0] extensions,
	output logic hit,
	output logic writeDenied,
	output csrPkg::csrData_t readData
);

	csrPkg::csrData_t vendorWord;
	csrPkg::csrData_t archWord;
	csrPkg::csrData_t implWord;
	csrPkg::csrData_t hartWord;
	csrPkg::csrData_t misaWord;
	csrPkg::csrData_t mscratch;
	csrPkg::csrData_t selValue;
	logic idSel;
	logic scratchSel;

	// Identity words, zero extended
	assign vendorWord = {21'b0, manufacturerId};
	assign archWord = {16'b0, partId};
	assign implWord = {28'b0, versionId};
	assign hartWord = {{(32-`CSR_HART_INDEX_WIDTH){1'b0}}, coreIndex};
	assign misaWord = {`CSR_MISA_MXL, 4'b0, extensions};

	always_comb begin
		idSel = 1'b1;
		scratchSel = 1'b0;
		selValue = '0;
		case (csrAddress)
			`CSR_ADDR_MVENDORID: selValue = vendorWord;
			`CSR_ADDR_MARCHID: selValue = archWord;
			`CSR_ADDR_MIMPID: selValue = implWord;
			`CSR_ADDR_MHARTID: selValue = hartWord;
			`CSR_ADDR_MISA: selValue = misaWord;
			`CSR_ADDR_MSCRATCH: begin
				idSel = 1'b0;
				scratchSel = 1'b1;
				selValue = mscratch;
			end
			default: idSel = 1'b0;
		endcase
	end

	// Visible to a read in the next cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mscratch <= '0;
		end else if (csrWriteEnable && scratchSel) begin
			mscratch <= csrWriteData;
		end
	end

	// A read beside a write still sees the old scratch word
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			hit <= 1'b0;
			writeDenied <= 1'b0;
			readData <= '0;
		end else begin
			hit <= (csrReadEnable || csrWriteEnable) && (idSel || scratchSel);
			writeDenied <= csrWriteEnable && idSel;
			if (csrReadEnable) begin
				readData <= selValue;
			end else begin
				readData <= '0;
			end
		end
	end

endmodule

/* logic/csrReadSelect.sv */
`timescale 1ns/10ps

module csrReadSelect (
	input logic clk,
	input logic arstN,
	input logic csrReadEnable,
	input logic csrWriteEnable,
	input logic cycleHit,
	input logic instretHit,
	input logic machineHit,
	input logic cycleDenied,
	input logic instretDenied,
	input logic machineDenied,
	input csrPkg::csrData_t cycleData,
	input csrPkg::csrData_t instretData,
	input csrPkg::csrData_t machineData,
	output csrPkg::csrData_t csrReadData,
	output logic illegalAccess
);

	logic accessPending;
	logic anyHit;
	logic anyDenied;

	// Tracks the request whose responses arrive now
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			accessPending <= 1'b0;
		end else begin
			accessPending <= csrReadEnable || csrWriteEnable;
		end
	end

	assign anyHit = cycleHit || instretHit || machineHit;
	assign anyDenied = cycleDenied || instretDenied || machineDenied;

	// Blocks drive zero unless they were read
	assign csrReadData = cycleData | instretData | machineData;

	// Unclaimed address or write to a read-only register
	assign illegalAccess = accessPending && (!anyHit || anyDenied);

	// Block address ranges must not overlap
	assert property (@(posedge clk) disable iff (!arstN)
		$onehot0({cycleHit, instretHit, machineHit}));

endmodule

/* logic/csrFile.sv */
`timescale 1ns/10ps

`include "csr_defines.svh"

module csrFile (
	input logic clk,
	input logic arstN,

	// CSR access
	input logic csrReadEnable,
	input logic csrWriteEnable,
	input csrPkg::csrAddr_t csrAddress,
	input csrPkg::csrData_t csrWriteData,
	output csrPkg::csrData_t csrReadData,
	output logic illegalAccess,

	// System inputs
	input logic [`CSR_HART_INDEX_WIDTH-1:0] coreIndex,
	input logic [10:0] manufacturerId,
	input logic [15:0] partId,
	input logic [3:0] versionId,
	input logic [25:0] extensions,
	input logic instructionCompleted
);

	logic cycleHit;
	logic cycleDenied;
	csrPkg::csrData_t cycleData;
	logic instretHit;
	logic instretDenied;
	csrPkg::csrData_t instretData;
	logic machineHit;
	logic machineDenied;
	csrPkg::csrData_t machineData;

	// Time reads back the cycle counter
	csrCounter #(
		.addrLow(`CSR_ADDR_CYCLE),
		.addrHigh(`CSR_ADDR_CYCLEH),
		.aliasLow(`CSR_ADDR_TIME),
		.aliasHigh(`CSR_ADDR_TIMEH)
	) cycleCounter (
		.clk(clk),
		.arstN(arstN),
		.countEnable(1'b1),
		.csrReadEnable(csrReadEnable),
		.csrWriteEnable(csrWriteEnable),
		.csrAddress(csrAddress),
		.hit(cycleHit),
		.writeDenied(cycleDenied),
		.readData(cycleData)
	);

	// No alias for instret
	csrCounter #(
		.addrLow(`CSR_ADDR_INSTRET),
		.addrHigh(`CSR_ADDR_INSTRETH),
		.aliasLow(`CSR_ADDR_INSTRET),
		.aliasHigh(`CSR_ADDR_INSTRETH)
	) instretCounter (
		.clk(clk),
		.arstN(arstN),
		.countEnable(instructionCompleted),
		.csrReadEnable(csrReadEnable),
		.csrWriteEnable(csrWriteEnable),
		.csrAddress(csrAddress),
		.hit(instretHit),
		.writeDenied(instretDenied),
		.readData(instretData)
	);

	csrMachineBank machineBank (
		.clk(clk),
		.arstN(arstN),
		.csrReadEnable(csrReadEnable),
		.csrWriteEnable(csrWriteEnable),
		.csrAddress(csrAddress),
		.csrWriteData(csrWriteData),
		.manufacturerId(manufacturerId),
		.partId(partId),
		.versionId(versionId),
		.coreIndex(coreIndex),
		.extensions(extensions),
		.hit(machineHit),
		.writeDenied(machineDenied),
		.readData(machineData)
	);

	csrReadSelect readSelect (
		.clk(clk),
		.arstN(arstN),
		.csrReadEnable(csrReadEnable),
		.csrWriteEnable(csrWriteEnable),
		.cycleHit(cycleHit),
		.instretHit(instretHit),
		.machineHit(machineHit),
		.cycleDenied(cycleDenied),
		.instretDenied(instretDenied),
		.machineDenied(machineDenied),
		.cycleData(cycleData),
		.instretData(instretData),
		.machineData(machineData),
		.csrReadData(csrReadData),
		.illegalAccess(illegalAccess)
	);

endmodule

/* bench/csrFileTb.sv */
`timescale 1ns/10ps

`include "csr_defines.svh"

module csrFileTb;

	localparam logic [1:0] opIdle = 2'd0;
	localparam logic [1:0] opRead = 2'd1;
	localparam logic [1:0] opWrite = 2'd2;
	localparam logic [1:0] opReadWrite = 2'd3;

	localparam logic [1:0] kindExact = 2'd0;
	localparam logic [1:0] kindDelta = 2'd1;
	localparam logic [1:0] kindIgnore = 2'd2;

	localparam int resetTimeout = 40;

	typedef struct {
		logic [1:0] op;
		csrPkg::csrAddr_t addr;
		csrPkg::csrData_t writeData;
		csrPkg::csrData_t expData;
		logic expIllegal;
		logic [1:0] kind;
		int refIndex;
		logic retire;
	} stimEntry_t;

	logic clk;
	logic arstN;
	logic csrReadEnable;
	logic csrWriteEnable;
	csrPkg::csrAddr_t csrAddress;
	csrPkg::csrData_t csrWriteData;
	csrPkg::csrData_t csrReadData;
	logic illegalAccess;
	logic [`CSR_HART_INDEX_WIDTH-1:0] coreIndex;
	logic [10:0] manufacturerId;
	logic [15:0] partId;
	logic [3:0] versionId;
	logic [25:0] extensions;
	logic instructionCompleted;

	stimEntry_t stimTable[$];
	csrPkg::csrData_t observed[$];
	logic [31:0] lcgState;
	int errorCount;
	int checkCount;

	csrFile i_dut (
		.clk(clk),
		.arstN(arstN),
		.csrReadEnable(csrReadEnable),
		.csrWriteEnable(csrWriteEnable),
		.csrAddress(csrAddress),
		.csrWriteData(csrWriteData),
		.csrReadData(csrReadData),
		.illegalAccess(illegalAccess),
		.coreIndex(coreIndex),
		.manufacturerId(manufacturerId),
		.partId(partId),
		.versionId(versionId),
		.extensions(extensions),
		.instructionCompleted(instructionCompleted)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	initial begin
		arstN = 1'b0;
		repeat (10) @(posedge clk);
		#2 arstN = 1'b1;
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// Retire strobe for each table slot
	function automatic logic retirePattern(input int slot);
		return (slot % 3 != 1) && (slot % 5 != 4);
	endfunction

	function automatic csrPkg::csrData_t retiredBetween(input int first, input int last);
		csrPkg::csrData_t total;
		total = '0;
		for (int k = first; k < last; k++) begin
			if (retirePattern(k)) begin
				total = total + 32'd1;
			end
		end
		return total;
	endfunction

	task automatic addEntry(input logic [1:0] op, input csrPkg::csrAddr_t addr,
		input csrPkg::csrData_t writeData, input csrPkg::csrData_t expData,
		input logic expIllegal, input logic [1:0] kind, input int refIndex);
		stimEntry_t entry;
		entry.op = op;
		entry.addr = addr;
		entry.writeData = writeData;
		entry.expData = expData;
		entry.expIllegal = expIllegal;
		entry.kind = kind;
		entry.refIndex = refIndex;
		entry.retire = retirePattern(stimTable.size());
		stimTable.push_back(entry);
	endtask

	task automatic setIdentity();
		logic [31:0] word;
		word = lcgNext();
		manufacturerId = word[10:0];
		word = lcgNext();
		partId = word[15:0];
		word = lcgNext();
		versionId = word[3:0];
		word = lcgNext();
		coreIndex = word[`CSR_HART_INDEX_WIDTH-1:0];
		word = lcgNext();
		extensions = word[25:0];
	endtask

	task automatic buildTable();
		csrPkg::csrData_t vendorWord;
		csrPkg::csrData_t archWord;
		csrPkg::csrData_t implWord;
		csrPkg::csrData_t hartWord;
		csrPkg::csrData_t misaWord;
		csrPkg::csrData_t scratchA;
		csrPkg::csrData_t scratchB;
		int cycleBase;
		int cycleHighBase;
		int instretBase;
		int instretLast;
		vendorWord = {21'b0, manufacturerId};
		archWord = {16'b0, partId};
		implWord = {28'b0, versionId};
		hartWord = csrPkg::csrData_t'(coreIndex);
		misaWord = {2'b01, 4'b0, extensions};
		scratchA = lcgNext();
		scratchB = lcgNext();

		// Quiet bus straight out of reset
		repeat (3) addEntry(opIdle, `CSR_ADDR_CYCLE, '0, '0, 1'b0, kindExact, 0);

		addEntry(opRead, `CSR_ADDR_MVENDORID, '0, vendorWord, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MARCHID, '0, archWord, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MIMPID, '0, implWord, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MHARTID, '0, hartWord, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MISA, '0, misaWord, 1'b0, kindExact, 0);

		addEntry(opRead, `CSR_ADDR_MSCRATCH, '0, '0, 1'b0, kindExact, 0);
		addEntry(opWrite, `CSR_ADDR_MSCRATCH, scratchA, '0, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MSCRATCH, '0, scratchA, 1'b0, kindExact, 0);
		// Same-cycle read sees the old word
		addEntry(opReadWrite, `CSR_ADDR_MSCRATCH, scratchB, scratchA, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MSCRATCH, '0, scratchB, 1'b0, kindExact, 0);

		cycleBase = stimTable.size();
		addEntry(opRead, `CSR_ADDR_CYCLE, '0, '0, 1'b0, kindIgnore, 0);
		addEntry(opRead, `CSR_ADDR_TIME, '0, 32'd1, 1'b0, kindDelta, cycleBase);
		addEntry(opIdle, `CSR_ADDR_TIME, '0, '0, 1'b0, kindExact, 0);
		addEntry(opIdle, `CSR_ADDR_TIME, '0, '0, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_CYCLE, '0, 32'd4, 1'b0, kindDelta, cycleBase);
		cycleHighBase = stimTable.size();
		addEntry(opRead, `CSR_ADDR_CYCLEH, '0, '0, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_TIMEH, '0, '0, 1'b0, kindDelta, cycleHighBase);

		instretBase = stimTable.size();
		addEntry(opRead, `CSR_ADDR_INSTRET, '0, retiredBetween(0, instretBase), 1'b0,
			kindExact, 0);
		addEntry(opIdle, `CSR_ADDR_MVENDORID, '0, '0, 1'b0, kindExact, 0);
		addEntry(opIdle, `CSR_ADDR_MVENDORID, '0, '0, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_INSTRET, '0, retiredBetween(instretBase, stimTable.size()),
			1'b0, kindDelta, instretBase);
		instretLast = stimTable.size();
		addEntry(opRead, `CSR_ADDR_INSTRET, '0, retiredBetween(instretLast - 1, instretLast),
			1'b0, kindDelta, instretLast - 1);
		addEntry(opRead, `CSR_ADDR_INSTRETH, '0, '0, 1'b0, kindExact, 0);

		addEntry(opRead, 12'h7C0, '0, '0, 1'b1, kindExact, 0);
		addEntry(opIdle, `CSR_ADDR_MISA, '0, '0, 1'b0, kindExact, 0);
		addEntry(opWrite, `CSR_ADDR_CYCLE, lcgNext(), '0, 1'b1, kindExact, 0);
		// Counter keeps running across the denied write
		addEntry(opRead, `CSR_ADDR_CYCLE, '0, stimTable.size() - cycleBase, 1'b0,
			kindDelta, cycleBase);
		addEntry(opWrite, `CSR_ADDR_INSTRET, lcgNext(), '0, 1'b1, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_INSTRET, '0, retiredBetween(instretLast, stimTable.size()),
			1'b0, kindDelta, instretLast);
		addEntry(opWrite, `CSR_ADDR_MVENDORID, lcgNext(), '0, 1'b1, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MVENDORID, '0, vendorWord, 1'b0, kindExact, 0);
		addEntry(opWrite, 12'h7C0, lcgNext(), '0, 1'b1, kindExact, 0);
		addEntry(opReadWrite, `CSR_ADDR_MISA, lcgNext(), misaWord, 1'b1, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MISA, '0, misaWord, 1'b0, kindExact, 0);
		addEntry(opRead, `CSR_ADDR_MSCRATCH, '0, scratchB, 1'b0, kindExact, 0);
		addEntry(opIdle, `CSR_ADDR_MSCRATCH, '0, '0, 1'b0, kindExact, 0);
		addEntry(opIdle, `CSR_ADDR_MSCRATCH, '0, '0, 1'b0, kindExact, 0);
	endtask

	task automatic driveIdle();
		csrReadEnable = 1'b0;
		csrWriteEnable = 1'b0;
		csrAddress = '0;
		csrWriteData = '0;
		instructionCompleted = 1'b0;
	endtask

	task automatic applyEntry(input stimEntry_t entry);
		csrReadEnable = entry.op[0];
		csrWriteEnable = entry.op[1];
		csrAddress = entry.addr;
		csrWriteData = entry.writeData;
		instructionCompleted = entry.retire;
	endtask

	task automatic checkResponse(input int index);
		stimEntry_t entry;
		csrPkg::csrData_t delta;
		entry = stimTable[index];
		observed.push_back(csrReadData);
		checkCount++;
		assert (illegalAccess === entry.expIllegal) else begin
			errorCount++;
			$display("[ERROR] illegalAccess at entry %0d (address %h): expected %h, got %h",
				index, entry.addr, entry.expIllegal, illegalAccess);
		end
		if (entry.kind == kindExact) begin
			checkCount++;
			assert (csrReadData === entry.expData) else begin
				errorCount++;
				$display("[ERROR] csrReadData at entry %0d (address %h): expected %h, got %h",
					index, entry.addr, entry.expData, csrReadData);
			end
		end else if (entry.kind == kindDelta) begin
			delta = csrReadData - observed[entry.refIndex];
			checkCount++;
			assert (delta === entry.expData) else begin
				errorCount++;
				$display("[ERROR] csrReadData delta at entry %0d (address %h): expected %h, got %h",
					index, entry.addr, entry.expData, delta);
			end
		end
	endtask

	task automatic waitForReset(output logic released);
		int cycles;
		cycles = 0;
		while (arstN !== 1'b1 && cycles < resetTimeout) begin
			@(negedge clk);
			cycles++;
			if (arstN !== 1'b1) begin
				checkCount++;
				assert (csrReadData === '0 && illegalAccess === 1'b0) else begin
					errorCount++;
					$display("[ERROR] csrReadData/illegalAccess in reset: expected 0/0, got %h/%h",
						csrReadData, illegalAccess);
				end
			end
		end
		released = (arstN === 1'b1);
	endtask

	// One entry per cycle with its response checked mid-cycle one cycle later
	task automatic runTable();
		for (int i = 0; i <= stimTable.size(); i++) begin
			@(posedge clk);
			#2;
			if (i < stimTable.size()) begin
				applyEntry(stimTable[i]);
			end else begin
				driveIdle();
			end
			if (i > 0) begin
				@(negedge clk);
				checkResponse(i - 1);
			end
		end
	endtask

	initial begin
		logic released;
		errorCount = 0;
		checkCount = 0;
		lcgState = 32'd73265;
		driveIdle();
		setIdentity();
		buildTable();
		waitForReset(released);
		if (released) begin
			runTable();
		end else begin
			errorCount++;
			$display("Reset was not released within %0d cycles", resetTimeout);
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+logic
logic/csrPkg.sv
logic/csrCounter.sv
logic/csrMachineBank.sv
logic/csrReadSelect.sv
logic/csrFile.sv
bench/csrFileTb.sv

/* Bender.yml */
package:
  name: csr_file

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/csrPkg.sv
      - logic/csrCounter.sv
      - logic/csrMachineBank.sv
      - logic/csrReadSelect.sv
      - logic/csrFile.sv

  - target: test
    include_dirs:
      - logic
    files:
      - bench/csrFileTb.sv
